// File: verilog/scaler_pkg.sv
package scaler_pkg;

	// source and destination lengths and indices.
	localparam int C_WIDTH = 12;

	// four thresholds plus an overflow code.
	localparam int C_SPLIT_ID_WIDTH = 2;
	localparam int C_SPLITS = 1 << C_SPLIT_ID_WIDTH;

	// doubled centers times a length.
	localparam int C_POS_WIDTH = 2 * C_WIDTH + 1;

	typedef logic [C_SPLIT_ID_WIDTH:0] split_id_t;

	typedef struct packed {
		logic                   valid;
		logic                   s_advance;
		logic                   m_first;
		logic                   m_last;
		logic                   a_last;
		logic [C_WIDTH-1:0]     idx0;
		logic [C_WIDTH-1:0]     idx1;
		logic [C_POS_WIDTH-1:0] s_c;
		logic [C_POS_WIDTH-1:0] m_c;
	} coord_rec_t;

	typedef struct packed {
		logic               s_advance;
		logic               m_first;
		logic               m_last;
		logic               a_last;
		logic [C_WIDTH-1:0] idx0;
		logic [C_WIDTH-1:0] idx1;
		split_id_t          split_id;
	} split_rec_t;

	typedef struct packed {
		logic [C_WIDTH-1:0]          idx0;
		logic [C_WIDTH-1:0]          idx1;
		logic [C_SPLIT_ID_WIDTH:0]   w0;
		logic [C_SPLIT_ID_WIDTH:0]   w1;
		logic                        line_start;
		logic                        line_end;
	} blend_out_t;

	typedef enum logic {
		IDLE,
		SHOW
	} blend_state_t;

endpackage

// File: verilog/scaler_stepper.sv
`timescale 1ns/1ps

module scaler_stepper import scaler_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               i_start,
	input  logic [C_WIDTH-1:0] i_s_nbr,
	input  logic [C_WIDTH-1:0] i_m_nbr,
	input  logic [C_WIDTH-1:0] i_lines,
	input  logic               i_enable,
	output coord_rec_t         o_rec,
	output logic               o_busy
);

	logic [C_WIDTH-1:0] s_nbr_r, m_nbr_r, lines_r;
	logic [C_WIDTH-1:0] q_r, r_r;
	logic [C_WIDTH-1:0] m_cnt, line_cnt;
	logic               s_adv_r, busy_r;

	// qa is the unclamped source index, ra the spare distance past its center.
	logic signed [C_WIDTH:0]     qa;
	logic [C_WIDTH:0]            ra;
	logic [C_POS_WIDTH-1:0]      s_c_r;
	logic signed [C_POS_WIDTH:0] m_c_raw;

	logic [C_WIDTH-1:0]          sel_s, sel_m, div_q, div_r;
	logic signed [C_WIDTH:0]     qa_init, qa_step, qa_next;
	logic [C_WIDTH:0]            ra_init, ra_next, two_m;
	logic [C_WIDTH+1:0]          ra_sum, ra_wrap;
	logic                        carry;
	logic signed [C_POS_WIDTH:0] mc_init, mc_step, mc_next;
	logic [C_POS_WIDTH-1:0]      sc_step, sc_next;
	logic [C_WIDTH-1:0]          s_cur, s_nxt;
	logic                        m_last, a_last;

	always_comb begin
		sel_s = i_start ? i_s_nbr : s_nbr_r;
		sel_m = i_start ? i_m_nbr : m_nbr_r;
		div_q = sel_s / sel_m;
		div_r = sel_s % sel_m;

		// first pixel of a line, in steps of two destination centers.
		qa_init = ($signed({1'b0, div_q}) - 1) >>> 1;
		ra_init = {1'b0, div_r} + (div_q[0] ? '0 : {1'b0, sel_m});
		mc_init = (C_POS_WIDTH+1)'(sel_s) - (C_POS_WIDTH+1)'(div_r)
			- (div_q[0] ? '0 : (C_POS_WIDTH+1)'(sel_m));

		// each step adds q source pixels, plus one on remainder carry.
		two_m   = {m_nbr_r, 1'b0};
		ra_sum  = {1'b0, ra} + {1'b0, r_r, 1'b0};
		carry   = ra_sum >= {1'b0, two_m};
		ra_wrap = carry ? ra_sum - {1'b0, two_m} : ra_sum;
		qa_step = qa + $signed({1'b0, q_r}) + $signed({{C_WIDTH{1'b0}}, carry});
		mc_step = m_c_raw + (C_POS_WIDTH+1)'({s_nbr_r - r_r, 1'b0})
			+ (carry ? (C_POS_WIDTH+1)'(two_m) : '0);
		sc_step = s_c_r + C_POS_WIDTH'({s_nbr_r, 1'b0});

		m_last  = (m_cnt == m_nbr_r - 1'b1);
		a_last  = m_last && (line_cnt == lines_r - 1'b1);

		qa_next = m_last ? qa_init : qa_step;
		ra_next = m_last ? ra_init : ra_wrap[C_WIDTH:0];
		mc_next = m_last ? mc_init : mc_step;
		sc_next = m_last ? C_POS_WIDTH'(sel_s) : sc_step;

		s_cur = qa[C_WIDTH] ? '0 : qa[C_WIDTH-1:0];
		s_nxt = qa_next[C_WIDTH] ? '0 : qa_next[C_WIDTH-1:0];
	end

	always_comb begin
		o_rec.valid     = busy_r;
		o_rec.s_advance = s_adv_r;
		o_rec.m_first   = (m_cnt == '0);
		o_rec.m_last    = m_last;
		o_rec.a_last    = a_last;
		o_rec.idx0      = s_cur;
		o_rec.idx1      = (s_cur == s_nbr_r - 1'b1) ? s_cur : s_cur + 1'b1;
		o_rec.s_c       = s_c_r;
		// left of the first source center, clamp to pixel 0.
		o_rec.m_c       = qa[C_WIDTH] ? C_POS_WIDTH'(m_nbr_r) : m_c_raw[C_POS_WIDTH-1:0];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy_r   <= 1'b0;
			m_cnt    <= '0;
			line_cnt <= '0;
			s_adv_r  <= 1'b0;
		end else if (i_start) begin
			busy_r   <= 1'b1;
			m_cnt    <= '0;
			line_cnt <= '0;
			s_adv_r  <= 1'b0;
		end else if (busy_r && i_enable) begin
			if (a_last)
				busy_r <= 1'b0;
			if (m_last) begin
				m_cnt    <= '0;
				line_cnt <= line_cnt + 1'b1;
				s_adv_r  <= 1'b0;
			end else begin
				m_cnt    <= m_cnt + 1'b1;
				s_adv_r  <= (s_nxt != s_cur);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_start) begin
			s_nbr_r <= i_s_nbr;
			m_nbr_r <= i_m_nbr;
			lines_r <= i_lines;
			q_r     <= div_q;
			r_r     <= div_r;
			qa      <= qa_init;
			ra      <= ra_init;
			s_c_r   <= C_POS_WIDTH'(i_s_nbr);
			m_c_raw <= mc_init;
		end else if (busy_r && i_enable) begin
			qa      <= qa_next;
			ra      <= ra_next;
			s_c_r   <= sc_next;
			m_c_raw <= mc_next;
		end
	end

	assign o_busy = busy_r;

	a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
		i_start |-> !o_busy);

endmodule

// File: verilog/scaler_spliter.sv
`timescale 1ns/1ps

module scaler_spliter import scaler_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic [C_WIDTH-1:0] i_m_nbr,
	input  logic               i_enable,
	input  coord_rec_t         i_rec,
	output logic               o_valid,
	output split_rec_t         o_rec
);

	logic [C_WIDTH:0] thr [C_SPLITS];

	logic                     s0_valid;
	split_rec_t               s0_rec;
	logic signed [C_WIDTH+1:0] s0_diff;
	logic [C_SPLITS-1:0]      cmp;

	logic       s1_valid;
	split_rec_t s1_rec;

	logic [C_POS_WIDTH-1:0] diff_full;
	split_id_t              id_enc;

	// n/4 of m_nbr, rounded down.
	function automatic logic [C_WIDTH:0] quarter(input logic [C_WIDTH-1:0] m,
		input int unsigned n);
		logic [C_WIDTH+2:0] p;
		p = m * (C_WIDTH+3)'(n);
		return p[C_WIDTH+2:2];
	endfunction

	// thresholds at 1/8, 3/8, 5/8 and 7/8 of a source step.
	always_ff @(posedge clk) begin
		for (int k = 0; k < C_SPLITS; k++)
			thr[k] <= quarter(i_m_nbr, 2 * k + 1);
	end

	assign diff_full = i_rec.s_c - i_rec.m_c;

	always_ff @(posedge clk) begin
		if (!resetn)
			s0_valid <= 1'b0;
		else if (i_enable)
			s0_valid <= i_rec.valid;
	end

	always_ff @(posedge clk) begin
		if (i_enable) begin
			s0_rec.s_advance <= i_rec.s_advance;
			s0_rec.m_first   <= i_rec.m_first;
			s0_rec.m_last    <= i_rec.m_last;
			s0_rec.a_last    <= i_rec.a_last;
			s0_rec.idx0      <= i_rec.idx0;
			s0_rec.idx1      <= i_rec.idx1;
			s0_rec.split_id  <= '0;
			// both neighbors are one pixel at the line edges.
			s0_diff <= (i_rec.idx0 == i_rec.idx1) ? '0 : diff_full[C_WIDTH+1:0];
		end
	end

	always_comb begin
		for (int k = 0; k < C_SPLITS; k++)
			cmp[k] = s0_diff <= $signed({1'b0, thr[k]});
	end

	// smallest matching threshold, overflow code otherwise.
	always_comb begin
		id_enc = split_id_t'(C_SPLITS);
		for (int k = C_SPLITS - 1; k >= 0; k--)
			if (cmp[k])
				id_enc = split_id_t'(k);
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			s1_valid <= 1'b0;
		else if (i_enable)
			s1_valid <= s0_valid;
	end

	always_ff @(posedge clk) begin
		if (i_enable) begin
			s1_rec          <= s0_rec;
			s1_rec.split_id <= id_enc;
		end
	end

	assign o_valid = s1_valid;
	assign o_rec   = s1_rec;

	a_thermometer: assert property (@(posedge clk) disable iff (!resetn)
		s0_valid |-> ((~cmp & (~cmp + 1'b1)) == '0));

endmodule

// File: verilog/split_fifo.sv
`timescale 1ns/1ps

module split_fifo import scaler_pkg::*; #(
	parameter int C_FIFO_DEPTH = 16
) (
	input  logic       clk,
	input  logic       resetn,
	input  logic       i_valid,
	input  split_rec_t i_rec,
	output logic       o_room,
	input  logic       i_pop,
	output logic       o_empty,
	output split_rec_t o_rec
);

	localparam int C_AW = $clog2(C_FIFO_DEPTH);

	split_rec_t mem [C_FIFO_DEPTH];

	// top bit tells a full buffer from an empty one.
	logic [C_AW:0] wr_ptr;
	logic [C_AW:0] rd_ptr;
	logic          full;
	logic          wr_en;

	assign full = (wr_ptr[C_AW] != rd_ptr[C_AW])
		&& (wr_ptr[C_AW-1:0] == rd_ptr[C_AW-1:0]);
	assign o_room  = !full;
	assign o_empty = (wr_ptr == rd_ptr);
	assign wr_en   = i_valid && !full;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[C_AW-1:0]] <= i_rec;
	end

	// head word is shown ahead of the pop.
	assign o_rec = mem[rd_ptr[C_AW-1:0]];

	a_no_underflow: assert property (@(posedge clk) disable iff (!resetn)
		i_pop |-> !o_empty);

endmodule

// File: verilog/blend_selector.sv
`timescale 1ns/1ps

module blend_selector import scaler_pkg::*; (
	input  logic       clk,
	input  logic       resetn,
	input  logic       i_ready,
	input  logic       i_empty,
	input  split_rec_t i_rec,
	output logic       o_pop,
	output logic       o_valid,
	output blend_out_t o_blend,
	output logic       o_frame_done
);

	blend_state_t state;
	blend_out_t   out_r;
	logic         done_r;

	assign o_pop = !i_empty && i_ready;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state  <= IDLE;
			done_r <= 1'b0;
		end else begin
			case (state)
				IDLE: if (o_pop) state <= SHOW;
				SHOW: if (!o_pop) state <= IDLE;
				default: state <= IDLE;
			endcase
			done_r <= o_pop && i_rec.a_last;
		end
	end

	// split id k puts k quarters on the right neighbor.
	always_ff @(posedge clk) begin
		if (o_pop) begin
			out_r.idx0       <= i_rec.idx0;
			out_r.idx1       <= i_rec.idx1;
			out_r.w1         <= i_rec.split_id;
			out_r.w0         <= split_id_t'(C_SPLITS) - i_rec.split_id;
			out_r.line_start <= i_rec.m_first;
			out_r.line_end   <= i_rec.m_last;
		end
	end

	assign o_valid      = (state == SHOW);
	assign o_blend      = out_r;
	assign o_frame_done = done_r;

	a_weights: assert property (@(posedge clk) disable iff (!resetn)
		o_valid |-> (o_blend.w0 + o_blend.w1) == C_SPLITS);

endmodule

// File: verilog/scaler_top.sv
`timescale 1ns/1ps

module scaler_top import scaler_pkg::*; #(
	parameter int C_FIFO_DEPTH = 16
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               i_start,
	input  logic [C_WIDTH-1:0] i_s_nbr,
	input  logic [C_WIDTH-1:0] i_m_nbr,
	input  logic [C_WIDTH-1:0] i_lines,
	input  logic               i_ready,
	output logic               o_valid,
	output blend_out_t         o_blend,
	output logic               o_frame_done,
	output logic               o_busy
);

	coord_rec_t step_rec;
	split_rec_t spl_rec;
	split_rec_t fifo_rec;
	logic       spl_valid;
	logic       room;
	logic       fifo_empty;
	logic       pop;

	// producer side freezes when the buffer is full.
	scaler_stepper u_stepper (
		.clk      (clk),
		.resetn   (resetn),
		.i_start  (i_start),
		.i_s_nbr  (i_s_nbr),
		.i_m_nbr  (i_m_nbr),
		.i_lines  (i_lines),
		.i_enable (room),
		.o_rec    (step_rec),
		.o_busy   (o_busy)
	);

	scaler_spliter u_spliter (
		.clk      (clk),
		.resetn   (resetn),
		.i_m_nbr  (i_m_nbr),
		.i_enable (room),
		.i_rec    (step_rec),
		.o_valid  (spl_valid),
		.o_rec    (spl_rec)
	);

	split_fifo #(
		.C_FIFO_DEPTH (C_FIFO_DEPTH)
	) u_fifo (
		.clk     (clk),
		.resetn  (resetn),
		.i_valid (spl_valid),
		.i_rec   (spl_rec),
		.o_room  (room),
		.i_pop   (pop),
		.o_empty (fifo_empty),
		.o_rec   (fifo_rec)
	);

	blend_selector u_blend (
		.clk          (clk),
		.resetn       (resetn),
		.i_ready      (i_ready),
		.i_empty      (fifo_empty),
		.i_rec        (fifo_rec),
		.o_pop        (pop),
		.o_valid      (o_valid),
		.o_blend      (o_blend),
		.o_frame_done (o_frame_done)
	);

endmodule

// File: bench/scaler_checker.sv
`timescale 1ns/1ps

module scaler_checker import scaler_pkg::*; (
	input  logic               clk,
	input  logic               resetn,
	input  logic               i_start,
	input  logic [C_WIDTH-1:0] i_s_nbr,
	input  logic [C_WIDTH-1:0] i_m_nbr,
	input  logic [C_WIDTH-1:0] i_lines,
	input  logic               i_valid,
	input  blend_out_t         i_blend,
	input  logic               i_frame_done,
	input  logic               i_busy,
	output int                 o_value_errors,
	output int                 o_seq_errors,
	output int                 o_beats,
	output int                 o_frames,
	output int                 o_pending
);

	blend_out_t exp_q[$];
	bit         last_q[$];
	int         value_errors = 0;
	int         seq_errors = 0;
	int         beats = 0;
	int         frames = 0;

	// expected beat for destination pixel m of a line.
	function automatic blend_out_t model_beat(input int s_nbr, input int m_nbr, input int m);
		blend_out_t b;
		int s_c;
		int m_c;
		int s;
		int offset;
		int k;
		int t;
		s_c = (2 * m + 1) * s_nbr;
		// largest source center at or below s_c.
		s = -1;
		while ((2 * (s + 1) + 1) * m_nbr <= s_c)
			s++;
		if (s < 0)
			s = 0;
		m_c = (2 * s + 1) * m_nbr;
		b.idx0 = C_WIDTH'(s);
		b.idx1 = (s + 1 > s_nbr - 1) ? C_WIDTH'(s_nbr - 1) : C_WIDTH'(s + 1);
		offset = (b.idx0 == b.idx1) ? 0 : s_c - m_c;
		k = 4;
		for (t = 3; t >= 0; t--)
			if ((m_nbr * (2 * t + 1)) / 4 >= offset)
				k = t;
		b.w1 = 3'(k);
		b.w0 = 3'(4 - k);
		b.line_start = (m == 0);
		b.line_end = (m == m_nbr - 1);
		return b;
	endfunction

	task automatic check_field(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("error %s: got %0h expected %0h (beat %0d)", name, got, exp, beats);
			value_errors++;
		end
	endtask

	always @(posedge clk) begin
		blend_out_t exp_b;
		bit         exp_last;
		int         ln;
		int         m;
		if (resetn && i_start) begin
			for (ln = 0; ln < int'(i_lines); ln++)
				for (m = 0; m < int'(i_m_nbr); m++) begin
					exp_q.push_back(model_beat(int'(i_s_nbr), int'(i_m_nbr), m));
					last_q.push_back(ln == int'(i_lines) - 1 && m == int'(i_m_nbr) - 1);
				end
		end
		if (resetn && i_valid) begin
			beats++;
			if (exp_q.size() == 0) begin
				$display("output beat %0d arrived with no expected beat left", beats);
				seq_errors++;
			end else begin
				exp_b = exp_q.pop_front();
				exp_last = last_q.pop_front();
				check_field("o_blend.idx0", int'(i_blend.idx0), int'(exp_b.idx0));
				check_field("o_blend.idx1", int'(i_blend.idx1), int'(exp_b.idx1));
				check_field("o_blend.w0", int'(i_blend.w0), int'(exp_b.w0));
				check_field("o_blend.w1", int'(i_blend.w1), int'(exp_b.w1));
				check_field("o_blend.line_start", int'(i_blend.line_start),
					int'(exp_b.line_start));
				check_field("o_blend.line_end", int'(i_blend.line_end), int'(exp_b.line_end));
				check_field("o_frame_done", int'(i_frame_done), int'(exp_last));
			end
		end
		if (resetn && i_frame_done) begin
			frames++;
			// stepper has long finished by now.
			check_field("o_busy", int'(i_busy), 0);
			if (!i_valid) begin
				$display("o_frame_done pulsed without an output beat");
				seq_errors++;
			end
		end
	end

	assign o_value_errors = value_errors;
	assign o_seq_errors   = seq_errors;
	assign o_beats        = beats;
	assign o_frames       = frames;
	assign o_pending      = exp_q.size();

endmodule

// File: bench/tb_scaler.sv
`timescale 1ns/1ps

module tb_scaler import scaler_pkg::*; ();

	localparam int C_FRAMES = 12;
	localparam int C_STALL_FACTOR = 4;

	logic               clk;
	logic               resetn;
	logic               i_start;
	logic               i_ready;
	logic [C_WIDTH-1:0] i_s_nbr;
	logic [C_WIDTH-1:0] i_m_nbr;
	logic [C_WIDTH-1:0] i_lines;
	logic               o_valid;
	logic               o_frame_done;
	logic               o_busy;
	blend_out_t         o_blend;

	int value_errors;
	int seq_errors;
	int beats;
	int frames;
	int pending;

	logic [16:0] lfsr_state = 17'd95925;
	int          f_s[C_FRAMES];
	int          f_m[C_FRAMES];
	int          f_l[C_FRAMES];
	int          f_stall[C_FRAMES];
	int          total_pixels = 0;
	int          run_left = 0;
	bit          budget_set = 1'b0;

	scaler_top #(
		.C_FIFO_DEPTH (16)
	) DUT (
		.clk          (clk),
		.resetn       (resetn),
		.i_start      (i_start),
		.i_s_nbr      (i_s_nbr),
		.i_m_nbr      (i_m_nbr),
		.i_lines      (i_lines),
		.i_ready      (i_ready),
		.o_valid      (o_valid),
		.o_blend      (o_blend),
		.o_frame_done (o_frame_done),
		.o_busy       (o_busy)
	);

	scaler_checker u_checker (
		.clk            (clk),
		.resetn         (resetn),
		.i_start        (i_start),
		.i_s_nbr        (i_s_nbr),
		.i_m_nbr        (i_m_nbr),
		.i_lines        (i_lines),
		.i_valid        (o_valid),
		.i_blend        (o_blend),
		.i_frame_done   (o_frame_done),
		.i_busy         (o_busy),
		.o_value_errors (value_errors),
		.o_seq_errors   (seq_errors),
		.o_beats        (beats),
		.o_frames       (frames),
		.o_pending      (pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// x^17 + x^14 + 1, maximal length.
	function automatic logic [16:0] lfsr_next(input logic [16:0] st);
		return {st[15:0], st[16] ^ st[13]};
	endfunction

	task automatic draw_bits(input int n, output int value);
		int i;
		value = 0;
		for (i = 0; i < n; i++) begin
			value = (value << 1) | int'(lfsr_state[16]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// short random gaps, or long runs of one level.
	task automatic update_ready(input int stall);
		int bits;
		if (stall != 0) begin
			if (run_left == 0) begin
				draw_bits(1, bits);
				i_ready = bits[0];
				draw_bits(4, bits);
				run_left = bits + 1;
			end
			run_left--;
		end else begin
			draw_bits(2, bits);
			i_ready = (bits != 0);
		end
	endtask

	task automatic run_frame(input int f);
		bit done;
		@(negedge clk);
		i_s_nbr = C_WIDTH'(f_s[f]);
		i_m_nbr = C_WIDTH'(f_m[f]);
		i_lines = C_WIDTH'(f_l[f]);
		i_start = 1'b1;
		update_ready(f_stall[f]);
		@(negedge clk);
		i_start = 1'b0;
		done = 1'b0;
		while (!done) begin
			update_ready(f_stall[f]);
			@(negedge clk);
			done = o_frame_done;
		end
	endtask

	initial begin
		int v;
		int f;
		int end_errors;
		resetn = 1'b0;
		i_start = 1'b0;
		i_ready = 1'b0;
		i_s_nbr = '0;
		i_m_nbr = '0;
		i_lines = '0;
		for (f = 0; f < C_FRAMES; f++) begin
			draw_bits(6, v);
			f_s[f] = v % 40 + 1;
			draw_bits(6, v);
			f_m[f] = v % 40 + 1;
			draw_bits(2, v);
			f_l[f] = v % 3 + 1;
			draw_bits(1, v);
			f_stall[f] = v;
			total_pixels += f_l[f] * f_m[f];
		end
		budget_set = 1'b1;
		repeat (4) @(negedge clk);
		resetn = 1'b1;
		for (f = 0; f < C_FRAMES; f++)
			run_frame(f);
		repeat (20) @(negedge clk);
		end_errors = 0;
		if (pending != 0) begin
			$display("%0d expected beats never appeared", pending);
			end_errors++;
		end
		if (frames != C_FRAMES) begin
			$display("saw %0d frame done pulses for %0d frames", frames, C_FRAMES);
			end_errors++;
		end
		if (beats != total_pixels) begin
			$display("saw %0d output beats but the frames hold %0d", beats, total_pixels);
			end_errors++;
		end
		if (o_busy) begin
			$display("o_busy still high after the last frame");
			end_errors++;
		end
		$display("%0d beats, %0d value errors, %0d sequence errors, %0d end-of-run errors",
			beats, value_errors, seq_errors, end_errors);
		if (value_errors + seq_errors + end_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog sized from the drawn frames.
	initial begin
		longint limit_ns;
		wait (budget_set);
		limit_ns = 64'(4 * (total_pixels + 20) * 8 * C_STALL_FACTOR);
		#(limit_ns);
		$display("timeout: the frames did not finish within %0d ns", limit_ns);
		$display("Something failed");
		$finish;
	end

endmodule

// File: list.f
verilog/scaler_pkg.sv
verilog/scaler_stepper.sv
verilog/scaler_spliter.sv
verilog/split_fifo.sv
verilog/blend_selector.sv
verilog/scaler_top.sv
bench/scaler_checker.sv
bench/tb_scaler.sv

// File: run.sh
#!/usr/bin/env bash
# builds and runs the scaler testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_scaler -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/Vtb_scaler > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
